/* files.f */
hdl/dma_pkg.sv
hdl/slot_fifo.sv
hdl/tx_msg_decoder.sv
hdl/rx_desc_issuer.sv
hdl/dma_controller.sv
tb/tb_dma_controller.sv

/* hdl/dma_controller.sv */
`timescale 1ns/1ns

module dma_controller import dma_pkg::*; #(
  parameter int                   DESC_FIFO_DEPTH = CORE_COUNT * SLOT_COUNT,
  parameter logic [LEN_WIDTH-1:0] DEF_MAX_PKT_LEN = 16'd2048
) (
  input  logic                     clk,
  input  logic                     rst,

  output logic [ADDR_WIDTH-1:0]    tx_desc_addr,
  output logic [LEN_WIDTH-1:0]     tx_desc_len,
  output logic [PORT_COUNT-1:0]    tx_desc_valid,
  input  logic [PORT_COUNT-1:0]    tx_desc_ready,

  output logic [ADDR_WIDTH-1:0]    rx_desc_addr,
  output logic [LEN_WIDTH-1:0]     rx_desc_len,
  output logic [PORT_COUNT-1:0]    rx_desc_valid,
  input  logic [PORT_COUNT-1:0]    rx_desc_ready,

  input  logic [PORT_COUNT-1:0]    incoming_pkt,
  input  logic [PORT_COUNT-1:0]    pkt_sent_out,

  input  msg_t                     msg_data,
  input  logic [CORE_NO_WIDTH-1:0] msg_core_no,
  input  logic                     msg_valid,
  output logic                     msg_ready,

  input  logic [CORE_COUNT-1:0]    drop_list,
  input  logic                     drop_list_valid,
  input  logic [LEN_WIDTH-1:0]     max_pkt_len,
  input  logic                     max_pkt_len_valid,

  input  slot_desc_t               inject_desc,
  input  logic                     inject_desc_valid,
  output logic                     inject_desc_ready,

  input  logic [SLOT_NO_WIDTH-1:0] slot_addr_wr_no,
  input  logic [SLOT_ADDR_EFF-1:0] slot_addr_wr_data,
  input  logic                     slot_addr_wr_valid
);

  logic [CORE_COUNT-1:0] drop_list_r;
  logic [LEN_WIDTH-1:0]  max_pkt_len_r;
  logic                  fifo_full;
  logic                  push_valid;
  slot_desc_t            push_desc;
  logic                  head_valid;
  slot_desc_t            head_desc;
  logic                  pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r   <= '0;
      max_pkt_len_r <= DEF_MAX_PKT_LEN;
    end else begin
      if (drop_list_valid)
        drop_list_r <= drop_list;
      if (max_pkt_len_valid)
        max_pkt_len_r <= max_pkt_len;
    end
  end

  tx_msg_decoder u_tx_msg_decoder (
    .clk               (clk),
    .rst               (rst),
    .msg_data          (msg_data),
    .msg_core_no       (msg_core_no),
    .msg_valid         (msg_valid),
    .msg_ready         (msg_ready),
    .tx_desc_addr      (tx_desc_addr),
    .tx_desc_len       (tx_desc_len),
    .tx_desc_valid     (tx_desc_valid),
    .tx_desc_ready     (tx_desc_ready),
    .pkt_sent_out      (pkt_sent_out),
    .inject_desc       (inject_desc),
    .inject_desc_valid (inject_desc_valid),
    .inject_desc_ready (inject_desc_ready),
    .fifo_full         (fifo_full),
    .push_valid        (push_valid),
    .push_desc         (push_desc)
  );

  slot_fifo #(
    .DEPTH (DESC_FIFO_DEPTH)
  ) u_slot_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_desc  (push_desc),
    .pop        (pop),
    .full       (fifo_full),
    .head_valid (head_valid),
    .head_desc  (head_desc)
  );

  rx_desc_issuer #(
    .DEF_MAX_PKT_LEN (DEF_MAX_PKT_LEN)
  ) u_rx_desc_issuer (
    .clk                (clk),
    .rst                (rst),
    .head_valid         (head_valid),
    .head_desc          (head_desc),
    .pop                (pop),
    .drop_list          (drop_list_r),
    .max_pkt_len        (max_pkt_len_r),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .rx_desc_ready      (rx_desc_ready),
    .incoming_pkt       (incoming_pkt),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_len        (rx_desc_len),
    .rx_desc_valid      (rx_desc_valid)
  );

endmodule

/* hdl/dma_pkg.sv */
package dma_pkg;

  localparam int CORE_COUNT      = 16;
  localparam int CORE_NO_WIDTH   = $clog2(CORE_COUNT);
  localparam int SLOT_COUNT      = 16;
  localparam int SLOT_NO_WIDTH   = $clog2(SLOT_COUNT);

  localparam int CORE_ADDR_WIDTH = 16;
  localparam int ADDR_WIDTH      = CORE_NO_WIDTH + CORE_ADDR_WIDTH;

  // Slot buffers are 256-byte aligned, the top core address bit stays zero
  localparam int SLOT_LEAD_ZERO  = 8;
  localparam int SLOT_ADDR_EFF   = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;

  // Write position of received data inside a slot buffer
  localparam logic [SLOT_LEAD_ZERO-1:0] RX_WRITE_OFFSET = 8'h0A;

  localparam int LEN_WIDTH       = 16;
  localparam int PORT_COUNT      = 2;

  typedef logic port_t;

  typedef struct packed {
    logic [CORE_NO_WIDTH-1:0] core_no;
    logic [SLOT_NO_WIDTH-1:0] slot_no;
  } slot_desc_t;

  // Core message, length in the low bits
  typedef struct packed {
    logic [15:0]                err_flags;
    logic [CORE_ADDR_WIDTH-1:0] slot_addr;
    logic [7:0]                 slot_no;
    logic [7:0]                 out_port;
    logic [LEN_WIDTH-1:0]       len;
  } msg_t;

endpackage

/* hdl/rx_desc_issuer.sv */
`timescale 1ns/1ns

module rx_desc_issuer import dma_pkg::*; #(
  parameter logic [LEN_WIDTH-1:0] DEF_MAX_PKT_LEN = 16'd2048
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     head_valid,
  input  slot_desc_t               head_desc,
  output logic                     pop,

  input  logic [CORE_COUNT-1:0]    drop_list,
  input  logic [LEN_WIDTH-1:0]     max_pkt_len,

  input  logic [SLOT_NO_WIDTH-1:0] slot_addr_wr_no,
  input  logic [SLOT_ADDR_EFF-1:0] slot_addr_wr_data,
  input  logic                     slot_addr_wr_valid,

  input  logic [PORT_COUNT-1:0]    rx_desc_ready,
  input  logic [PORT_COUNT-1:0]    incoming_pkt,

  output logic [ADDR_WIDTH-1:0]    rx_desc_addr,
  output logic [LEN_WIDTH-1:0]     rx_desc_len,
  output logic [PORT_COUNT-1:0]    rx_desc_valid
);

  localparam int PEND_WIDTH = 10;
  localparam int ADDR_GAP   = CORE_ADDR_WIDTH - SLOT_ADDR_EFF - SLOT_LEAD_ZERO;

  logic [SLOT_ADDR_EFF-1:0] slot_addr_mem [SLOT_COUNT];
  logic                     stage_valid;
  slot_desc_t               stage_desc;
  logic [SLOT_ADDR_EFF-1:0] stage_addr;
  logic                     drop;
  logic [PORT_COUNT-1:0]    ready_to_send;
  logic [PORT_COUNT-1:0]    can_receive;
  logic [PORT_COUNT-1:0]    grant;
  logic [PEND_WIDTH-1:0]    pending [PORT_COUNT];
  port_t                    last_port;

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid)
      slot_addr_mem[slot_addr_wr_no] <= slot_addr_wr_data;
  end

  // Lookup stage shadows the FIFO head, the head is only popped on its way out
  always_ff @(posedge clk) begin
    if (rst)
      stage_valid <= 1'b0;
    else
      stage_valid <= head_valid && !pop;
  end

  always_ff @(posedge clk) begin
    stage_desc <= head_desc;
    stage_addr <= slot_addr_mem[head_desc.slot_no];
  end

  assign drop = drop_list[stage_desc.core_no];

  always_comb begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      ready_to_send[p] = stage_valid && !drop && rx_desc_ready[p];
      can_receive[p]   = ready_to_send[p] && ((pending[p] != '0) || incoming_pkt[p]);
    end
  end

  // Alternate ports when both can take a descriptor
  always_comb begin
    grant = '0;
    if (can_receive[~last_port])
      grant[~last_port] = 1'b1;
    else if (can_receive[last_port])
      grant[last_port] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst)
      last_port <= port_t'(1'b1);
    else if (|grant)
      last_port <= port_t'(grant[1]);
  end

  // An incoming pulse served in its own cycle never reaches the counter
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        pending[p] <= '0;
      end
    end else begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        if (incoming_pkt[p] && !grant[p])
          pending[p] <= pending[p] + 1'b1;
        else if (grant[p] && !incoming_pkt[p])
          pending[p] <= pending[p] - 1'b1;
      end
    end
  end

  assign pop           = stage_valid && (drop || (|grant));
  assign rx_desc_valid = grant;
  assign rx_desc_addr  = {stage_desc.core_no, {ADDR_GAP{1'b0}}, stage_addr, RX_WRITE_OFFSET};

  // A zero receive size is unusable
  assign rx_desc_len = (max_pkt_len != '0) ? max_pkt_len : DEF_MAX_PKT_LEN;

  rx_valid_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(rx_desc_valid)
  );

endmodule

/* hdl/slot_fifo.sv */
`timescale 1ns/1ns

module slot_fifo import dma_pkg::*; #(
  parameter int DEPTH = 256
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push_valid,
  input  slot_desc_t push_desc,
  input  logic       pop,
  output logic       full,
  output logic       head_valid,
  output slot_desc_t head_desc
);

  localparam int PTR_WIDTH = $clog2(DEPTH);

  slot_desc_t           mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 empty;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full       = (count == (PTR_WIDTH + 1)'(DEPTH));
  assign empty      = (count == '0);
  assign head_valid = !empty;
  assign head_desc  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_valid)
      mem[wr_ptr] <= push_desc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Recycled slots never outnumber the slots that exist
  push_when_full: assert property (
    @(posedge clk) disable iff (rst) push_valid |-> !full
  );

  pop_when_empty: assert property (
    @(posedge clk) disable iff (rst) pop |-> !empty
  );

endmodule

/* hdl/tx_msg_decoder.sv */
`timescale 1ns/1ns

module tx_msg_decoder import dma_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,

  input  msg_t                     msg_data,
  input  logic [CORE_NO_WIDTH-1:0] msg_core_no,
  input  logic                     msg_valid,
  output logic                     msg_ready,

  output logic [ADDR_WIDTH-1:0]    tx_desc_addr,
  output logic [LEN_WIDTH-1:0]     tx_desc_len,
  output logic [PORT_COUNT-1:0]    tx_desc_valid,
  input  logic [PORT_COUNT-1:0]    tx_desc_ready,

  input  logic [PORT_COUNT-1:0]    pkt_sent_out,

  input  slot_desc_t               inject_desc,
  input  logic                     inject_desc_valid,
  output logic                     inject_desc_ready,

  input  logic                     fifo_full,
  output logic                     push_valid,
  output slot_desc_t               push_desc
);

  port_t      msg_port;
  logic       msg_accept;
  logic       accept_r;
  logic       desc_valid_r;
  port_t      desc_port_r;
  slot_desc_t desc_slot_r;
  slot_desc_t last_sent [PORT_COUNT];
  logic       recycle;

  assign msg_port = port_t'(msg_data.out_port[0]);

  // One idle cycle after every accepted message
  assign msg_ready  = !accept_r && tx_desc_ready[msg_port];
  assign msg_accept = msg_valid && msg_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      accept_r     <= 1'b0;
      desc_valid_r <= 1'b0;
    end else begin
      accept_r     <= msg_accept;
      // Zero length frees nothing on the wire, no descriptor
      desc_valid_r <= msg_accept && (msg_data.len != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (msg_accept) begin
      tx_desc_addr        <= {msg_core_no, msg_data.slot_addr};
      tx_desc_len         <= msg_data.len;
      desc_port_r         <= msg_port;
      desc_slot_r.core_no <= msg_core_no;
      desc_slot_r.slot_no <= msg_data.slot_no[SLOT_NO_WIDTH-1:0];
    end
  end

  always_comb begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      tx_desc_valid[p] = desc_valid_r && (desc_port_r == port_t'(p));
    end
  end

  // Slot owned by the packet now in flight on each port
  always_ff @(posedge clk) begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (tx_desc_valid[p])
        last_sent[p] <= desc_slot_r;
    end
  end

  assign recycle           = |pkt_sent_out;
  assign inject_desc_ready = !recycle && !fifo_full;
  assign push_valid        = recycle || (inject_desc_valid && inject_desc_ready);

  always_comb begin
    if (pkt_sent_out[1])
      push_desc = last_sent[1];
    else if (pkt_sent_out[0])
      push_desc = last_sent[0];
    else
      push_desc = inject_desc;
  end

  tx_valid_single: assert property (
    @(posedge clk) disable iff (rst) (|tx_desc_valid) |=> !(|tx_desc_valid)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_controller \
  -f files.f -o sim_tb_dma_controller
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_dma_controller)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

/* tb/tb_dma_controller.sv */
`timescale 1ns/1ns

module tb_dma_controller import dma_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int N_TX         = 24;
  localparam int N_ZERO       = 6;
  localparam int N_INJECT     = 20;
  localparam int N_DROP       = 24;
  localparam int N_RECYCLE    = 8;
  localparam int TX_CYCLES    = (N_TX + N_ZERO) * 10;
  localparam int RX_CYCLES    = (N_INJECT + N_DROP) * 20 + 100;
  localparam int RCY_CYCLES   = N_RECYCLE * 30;
  // Four times the summed test lengths, 4 ns per cycle
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TX_CYCLES + RX_CYCLES + RCY_CYCLES) * 4 * 4;

  logic                     clk = 1'b0;
  logic                     rst;
  logic [ADDR_WIDTH-1:0]    tx_desc_addr, rx_desc_addr;
  logic [LEN_WIDTH-1:0]     tx_desc_len, rx_desc_len, max_pkt_len;
  logic [PORT_COUNT-1:0]    tx_desc_valid, tx_desc_ready, rx_desc_valid, rx_desc_ready;
  logic [PORT_COUNT-1:0]    incoming_pkt, pkt_sent_out;
  msg_t                     msg_data;
  logic [CORE_NO_WIDTH-1:0] msg_core_no;
  logic                     msg_valid, msg_ready;
  logic [CORE_COUNT-1:0]    drop_list;
  logic                     drop_list_valid, max_pkt_len_valid;
  slot_desc_t               inject_desc;
  logic                     inject_desc_valid, inject_desc_ready;
  logic [SLOT_NO_WIDTH-1:0] slot_addr_wr_no;
  logic [SLOT_ADDR_EFF-1:0] slot_addr_wr_data;
  logic                     slot_addr_wr_valid;

  // Model
  logic [31:0]              lfsr = 32'h4199;
  slot_desc_t               free_q [$];
  logic [SLOT_ADDR_EFF-1:0] slot_tbl [SLOT_COUNT];
  slot_desc_t               last_tx [PORT_COUNT];
  int                       pend_m [PORT_COUNT];
  int                       rx_cnt [PORT_COUNT];
  int                       in_cnt [PORT_COUNT];
  logic [CORE_COUNT-1:0]    drop_m = '0;
  logic [LEN_WIDTH-1:0]     max_len_m = 16'd2048;
  logic [PORT_COUNT-1:0]    exp_tx_valid;
  logic [ADDR_WIDTH-1:0]    exp_tx_addr;
  logic [LEN_WIDTH-1:0]     exp_tx_len;
  slot_desc_t               exp_tx_slot;
  logic                     accepted_prev;
  logic [7:0]               bp_bits;
  string                    test_name = "reset";
  int                       err_count = 0;
  int                       test_count = 0;
  int                       failed_tests = 0;

  dma_controller u_dma_controller (.*);

  always #2 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    err_count++;
  endtask

  task automatic fail_msg(input string what);
    $display("test %s: %s", test_name, what);
    err_count++;
  endtask

  // Ready on each port is low about a quarter of the time
  always begin
    @(negedge clk);
    bp_bits = 8'(rand_bits(8));
    @(posedge clk);
    tx_desc_ready <= {|bp_bits[3:2], |bp_bits[1:0]};
    rx_desc_ready <= {|bp_bits[7:6], |bp_bits[5:4]};
  end

  always @(negedge clk) begin
    port_t      p;
    slot_desc_t exp_slot;
    if (rst) begin
      accepted_prev = 1'b0;
      exp_tx_valid  = '0;
    end else begin
      if (msg_ready !== (!accepted_prev && tx_desc_ready[msg_data.out_port[0]]))
        fail_value("msg_ready", !accepted_prev && tx_desc_ready[msg_data.out_port[0]], msg_ready);
      if (tx_desc_valid !== exp_tx_valid) begin
        fail_value("tx_desc_valid", exp_tx_valid, tx_desc_valid);
      end else if (exp_tx_valid != '0) begin
        if (tx_desc_addr !== exp_tx_addr)
          fail_value("tx_desc_addr", exp_tx_addr, tx_desc_addr);
        if (tx_desc_len !== exp_tx_len)
          fail_value("tx_desc_len", exp_tx_len, tx_desc_len);
        last_tx[exp_tx_valid[1]] = exp_tx_slot;
      end
      accepted_prev = msg_valid && msg_ready;
      exp_tx_valid  = '0;
      if (accepted_prev && msg_data.len != '0) begin
        exp_tx_valid[msg_data.out_port[0]] = 1'b1;
        exp_tx_addr = {msg_core_no, msg_data.slot_addr};
        exp_tx_len  = msg_data.len;
        exp_tx_slot = {msg_core_no, msg_data.slot_no[SLOT_NO_WIDTH-1:0]};
      end
      // Recycled slots go first, port 1 ahead of port 0
      if (pkt_sent_out != '0) begin
        if (inject_desc_ready)
          fail_msg("inject_desc_ready high while a slot is recycled");
        exp_slot = pkt_sent_out[1] ? last_tx[1] : last_tx[0];
        if (!drop_m[exp_slot.core_no])
          free_q.push_back(exp_slot);
      end else if (inject_desc_valid && inject_desc_ready && !drop_m[inject_desc.core_no]) begin
        free_q.push_back(inject_desc);
      end
      if (rx_desc_valid != '0) begin
        p = rx_desc_valid[1];
        if (rx_desc_valid == 2'b11)
          fail_msg("receive descriptor on both ports at once");
        if (!rx_desc_ready[p])
          fail_msg("receive descriptor on a port that is not ready");
        if (pend_m[p] == 0 && !incoming_pkt[p])
          fail_msg("receive descriptor on a port with no pending packet");
        if (free_q.size() == 0) begin
          fail_msg("receive descriptor with no free slot expected");
        end else begin
          exp_slot = free_q.pop_front();
          if (rx_desc_addr !== {exp_slot.core_no, 1'b0, slot_tbl[exp_slot.slot_no], 8'h0A})
            fail_value("rx_desc_addr", {exp_slot.core_no, 1'b0, slot_tbl[exp_slot.slot_no],
                       8'h0A}, rx_desc_addr);
          if (rx_desc_len !== max_len_m)
            fail_value("rx_desc_len", max_len_m, rx_desc_len);
        end
        rx_cnt[p]++;
      end
      for (int q = 0; q < PORT_COUNT; q++) begin
        if (incoming_pkt[q])
          in_cnt[q]++;
        if (incoming_pkt[q] && !rx_desc_valid[q])
          pend_m[q]++;
        else if (rx_desc_valid[q] && !incoming_pkt[q])
          pend_m[q]--;
      end
    end
  end

  task automatic send_msg(input msg_t m, input logic [CORE_NO_WIDTH-1:0] core);
    int waited;
    waited = 0;
    @(posedge clk);
    msg_data    <= m;
    msg_core_no <= core;
    msg_valid   <= 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!msg_ready && waited < 64);
    if (!msg_ready)
      fail_msg("message was not accepted within 64 cycles");
    @(posedge clk);
    msg_valid <= 1'b0;
  endtask

  task automatic inject(input slot_desc_t d);
    int waited;
    waited = 0;
    @(posedge clk);
    inject_desc       <= d;
    inject_desc_valid <= 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!inject_desc_ready && waited < 64);
    if (!inject_desc_ready)
      fail_msg("injected descriptor was not taken within 64 cycles");
    @(posedge clk);
    inject_desc_valid <= 1'b0;
  endtask

  task automatic pulse(input logic [PORT_COUNT-1:0] sent, input logic [PORT_COUNT-1:0] inc);
    @(posedge clk);
    pkt_sent_out <= sent;
    incoming_pkt <= inc;
    @(posedge clk);
    pkt_sent_out <= '0;
    incoming_pkt <= '0;
  endtask

  task automatic set_config(input logic [CORE_COUNT-1:0] drops, input logic [LEN_WIDTH-1:0] len);
    @(posedge clk);
    drop_list         <= drops;
    drop_list_valid   <= 1'b1;
    max_pkt_len       <= len;
    max_pkt_len_valid <= 1'b1;
    drop_m    = drops;
    max_len_m = len;
    @(posedge clk);
    drop_list_valid   <= 1'b0;
    max_pkt_len_valid <= 1'b0;
  endtask

  task automatic write_slot_table();
    for (int s = 0; s < SLOT_COUNT; s++) begin
      @(posedge clk);
      slot_tbl[s] = SLOT_ADDR_EFF'(rand_bits(SLOT_ADDR_EFF));
      slot_addr_wr_no    <= SLOT_NO_WIDTH'(s);
      slot_addr_wr_data  <= slot_tbl[s];
      slot_addr_wr_valid <= 1'b1;
    end
    @(posedge clk);
    slot_addr_wr_valid <= 1'b0;
  endtask

  // Last entry uses core 0, which is never dropped, so every entry leaves the FIFO
  task automatic issue_slots(input int n);
    slot_desc_t d;
    for (int i = 0; i < n; i++) begin
      d = 8'(rand_bits(8));
      if (i == n - 1)
        d.core_no = '0;
      inject(d);
      if (!drop_m[d.core_no])
        pulse('0, 2'b01 << rand_bits(1));
    end
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while ((free_q.size() != 0 || pend_m[0] != 0 || pend_m[1] != 0) && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (free_q.size() != 0 || pend_m[0] != 0 || pend_m[1] != 0)
      fail_msg($sformatf("free slots were not all issued within %0d cycles", limit));
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (rx_cnt[p] != in_cnt[p])
        fail_value($sformatf("rx count port %0d", p), in_cnt[p], rx_cnt[p]);
    end
    @(posedge clk);
  endtask

  task automatic finish_test(input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s passed", test_name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", test_name, err_count - errs_before);
    end
  endtask

  initial begin
    msg_t m;
    int   errs;
    rst = 1'b1;
    {tx_desc_ready, rx_desc_ready, incoming_pkt, pkt_sent_out} = '1 << 4;
    {msg_data, msg_core_no, msg_valid} = '0;
    {drop_list, drop_list_valid, max_pkt_len, max_pkt_len_valid} = '0;
    {inject_desc, inject_desc_valid} = '0;
    {slot_addr_wr_no, slot_addr_wr_data, slot_addr_wr_valid} = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset_state";
    errs = err_count;
    @(negedge clk);
    if (inject_desc_ready !== 1'b1)
      fail_value("inject_desc_ready", 1, inject_desc_ready);
    if (rx_desc_valid !== '0)
      fail_value("rx_desc_valid", 0, rx_desc_valid);
    @(posedge clk);
    finish_test(errs);

    for (int t = 0; t < 2; t++) begin
      test_name = (t == 0) ? "tx_random" : "tx_zero_len";
      errs = err_count;
      repeat ((t == 0) ? N_TX : N_ZERO) begin
        m[63:32] = rand_bits(32);
        m[31:0]  = rand_bits(32);
        m.len    = (t == 0) ? (m.len | 16'd1) : '0;
        send_msg(m, CORE_NO_WIDTH'(rand_bits(CORE_NO_WIDTH)));
      end
      repeat (2) @(posedge clk);
      finish_test(errs);
    end

    test_name = "rx_inject";
    errs = err_count;
    write_slot_table();
    rx_cnt = '{0, 0};
    in_cnt = '{0, 0};
    issue_slots(N_INJECT);
    wait_drain(RX_CYCLES);
    finish_test(errs);

    test_name = "rx_drop";
    errs = err_count;
    set_config(CORE_COUNT'(rand_bits(CORE_COUNT)) & 16'hFFFE, 16'(rand_bits(16)) | 16'h0040);
    rx_cnt = '{0, 0};
    in_cnt = '{0, 0};
    issue_slots(N_DROP);
    wait_drain(RX_CYCLES);
    set_config('0, max_len_m);
    finish_test(errs);

    test_name = "recycle";
    errs = err_count;
    rx_cnt = '{0, 0};
    in_cnt = '{0, 0};
    repeat (N_RECYCLE) begin
      m[63:32] = rand_bits(32);
      m[31:0]  = rand_bits(32);
      m.len    = m.len | 16'd1;
      send_msg(m, CORE_NO_WIDTH'(rand_bits(CORE_NO_WIDTH)));
      pulse(2'b01 << m.out_port[0], '0);
      pulse('0, 2'b01 << rand_bits(1));
    end
    wait_drain(RCY_CYCLES);
    finish_test(errs);

    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
    if (err_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
